/* ray_shader_top.f */
rtl/shader_pkg.sv
rtl/shade_req_if.sv
rtl/ray_id_free_list.sv
rtl/result_arbiter.sv
rtl/shade_queue.sv
rtl/simple_shader_unit.sv
rtl/ray_shader_top.sv
verification/ray_shader_tb.sv

/* verification/ray_shader_tb.sv */
`default_nettype none

module ray_shader_tb;
  import shader_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  logic        prg_valid;
  pixel_id_t   prg_pixel_id;
  vec3_t       prg_origin;
  vec3_t       prg_dir;
  logic        prg_stall;
  // sources in order pcalc, int, sint result and ss
  logic [3:0]  src_valid;
  ray_id_t     src_id [4];
  wire  [3:0]  src_stall;
  tri_id_t     pcalc_tri_id;
  logic        pb_we;
  pixel_id_t   pb_pixel_id;
  color_t      pb_color;
  logic        pb_full;
  logic        sint_valid;
  ray_id_t     sint_ray_id;
  vec3_t       sint_origin;
  vec3_t       sint_dir;
  logic        sint_stall;
  logic        raystore_we;
  ray_id_t     raystore_addr;
  vec3_t       raystore_origin;
  vec3_t       raystore_dir;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rng;
  pixel_id_t   issued_pix [NUM_RAYS];
  ray_id_t     free_q [$];
  ray_id_t     live_q [$];
  pixel_id_t   exp_pix [$];
  color_t      exp_col [$];

  ray_shader_top ray_shader_top_inst (
    .clk, .rst_n, .prg_valid, .prg_pixel_id, .prg_origin, .prg_dir, .prg_stall,
    .pcalc_valid (src_valid[0]), .pcalc_ray_id (src_id[0]), .pcalc_tri_id,
    .pcalc_stall (src_stall[0]),
    .int_valid (src_valid[1]), .int_ray_id (src_id[1]), .int_stall (src_stall[1]),
    .sint_res_valid (src_valid[2]), .sint_res_ray_id (src_id[2]),
    .sint_res_stall (src_stall[2]),
    .ss_valid (src_valid[3]), .ss_ray_id (src_id[3]), .ss_stall (src_stall[3]),
    .pb_we, .pb_pixel_id, .pb_color, .pb_full,
    .sint_valid, .sint_ray_id, .sint_origin, .sint_dir, .sint_stall,
    .raystore_we, .raystore_addr, .raystore_origin, .raystore_dir
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers and compare tasks
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand_word(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  // pcalc follows tri_id mod 4 and int is triangle 0
  // sint and ss results are misses
  function automatic color_t expected_color(input int src, input tri_id_t t);
    if (src == 1) return TRI0_COLOR;
    if (src != 0) return MISS_COLOR;
    case (t % 4)
      0: return TRI0_COLOR;
      1: return TRI1_COLOR;
      2: return TRI2_COLOR;
      default: return TRI3_COLOR;
    endcase
  endfunction

  task automatic check_ray_id(input string name, input ray_id_t got, input ray_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_pixel_id(input string name, input pixel_id_t got, input pixel_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_vec(input string name, input vec3_t got, input vec3_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // results leave the pixel buffer port in acceptance order
  always @(negedge clk) begin
    if (rst_n && pb_we) begin
      if (pb_full) begin
        errors++;
        $display("pixel buffer written while full");
      end
      if (exp_pix.size() == 0) begin
        errors++;
        $display("pixel buffer write with no result outstanding");
      end else begin
        check_pixel_id("pb_pixel_id", pb_pixel_id, exp_pix.pop_front());
        check_color("pb_color", pb_color, exp_col.pop_front());
      end
    end
  end

  task automatic issue_ray(output ray_id_t id, output int waited);
    ray_id_t     exp_id;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    exp_id = free_q.pop_front();
    rand_word(r0);
    rand_word(r1);
    rand_word(r2);
    prg_valid    = 1'b1;
    prg_pixel_id = pixel_id_t'(r0);
    prg_origin   = {r1, r2[15:0]};
    prg_dir      = {r2, r1[31:16]};
    waited = 0;
    @(negedge clk);
    while (!raystore_we) begin
      if (sint_valid && !sint_stall) begin
        errors++;
        $display("ray sent to the intersector without a ray store write");
      end
      waited++;
      @(negedge clk);
    end
    check_bit("sint_valid", sint_valid, 1'b1);
    check_ray_id("raystore_addr", raystore_addr, exp_id);
    check_ray_id("sint_ray_id", sint_ray_id, exp_id);
    check_vec("raystore_origin", raystore_origin, prg_origin);
    check_vec("raystore_dir", raystore_dir, prg_dir);
    check_vec("sint_origin", sint_origin, prg_origin);
    check_vec("sint_dir", sint_dir, prg_dir);
    issued_pix[exp_id] = prg_pixel_id;
    live_q.push_back(exp_id);
    id = raystore_addr;
    @(posedge clk);
    #2;
    prg_valid = 1'b0;
  endtask

  task automatic return_ray(input int src, input ray_id_t id, input tri_id_t t);
    src_valid[src] = 1'b1;
    src_id[src]    = id;
    if (src == 0) pcalc_tri_id = t;
    @(negedge clk);
    while (src_stall[src]) @(negedge clk);
    exp_pix.push_back(issued_pix[id]);
    exp_col.push_back(expected_color(src, t));
    free_q.push_back(id);
    @(posedge clk);
    #2;
    src_valid[src] = 1'b0;
  endtask

  task automatic drain_results;
    while (exp_pix.size() != 0) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic issue_after_init;
    ray_id_t id;
    int      waited;
    issue_ray(id, waited);
    if (waited < NUM_RAYS) begin
      errors++;
      $display("first ray issued after only %0d cycles of init", waited);
    end
    repeat (7) issue_ray(id, waited);
    sint_stall = 1'b1;
    prg_valid  = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_bit("prg_stall", prg_stall, 1'b1);
      check_bit("raystore_we", raystore_we, 1'b0);
      @(posedge clk);
      #2;
    end
    sint_stall = 1'b0;
    prg_valid  = 1'b0;
  endtask

  task automatic shade_returned_rays;
    logic [31:0] r;
    for (int k = 0; k < 8; k++) begin
      rand_word(r);
      // the first four go to pcalc, one for each triangle colour
      return_ray((k < 4) ? 0 : k % 4, live_q.pop_front(), tri_id_t'({r[15:2], k[1:0]}));
    end
    drain_results();
  endtask

  task automatic round_robin_arbitration;
    ray_id_t     id;
    int          waited;
    int          transfers;
    logic [3:0]  done;
    logic [3:0]  acc;
    logic [3:0]  spare;
    ray_id_t     next_id [4];
    logic [31:0] r;
    repeat (8) issue_ray(id, waited);
    rand_word(r);
    pcalc_tri_id = tri_id_t'(r);
    for (int s = 0; s < 4; s++) src_id[s] = live_q.pop_front();
    for (int s = 0; s < 4; s++) next_id[s] = live_q.pop_front();
    // every source has a second ray queued behind the first
    spare     = 4'hf;
    src_valid = 4'hf;
    done      = '0;
    transfers = 0;
    while (src_valid != 0) begin
      @(negedge clk);
      acc = src_valid & ~src_stall;
      if ((acc & (acc - 1'b1)) != 0) begin
        errors++;
        $display("more than one source accepted in one cycle");
      end
      for (int s = 0; s < 4; s++) begin
        if (acc[s]) begin
          exp_pix.push_back(issued_pix[src_id[s]]);
          exp_col.push_back(expected_color(s, pcalc_tri_id));
          free_q.push_back(src_id[s]);
          if (transfers < 4) begin
            if (done[s]) begin
              errors++;
              $display("source %0d accepted twice within four transfers", s);
            end
            done[s] = 1'b1;
          end
        end
      end
      if (acc != 0) transfers++;
      @(posedge clk);
      #2;
      for (int s = 0; s < 4; s++) begin
        if (acc[s] && spare[s]) begin
          src_id[s] = next_id[s];
          spare[s]  = 1'b0;
        end else if (acc[s]) begin
          src_valid[s] = 1'b0;
        end
      end
    end
    if (done != 4'hf) begin
      errors++;
      $display("not every source was accepted within the first four transfers");
    end
    drain_results();
  endtask

  task automatic hold_pixel_buffer;
    ray_id_t id;
    int      waited;
    repeat (5) issue_ray(id, waited);
    pb_full = 1'b1;
    repeat (4) return_ray(2, live_q.pop_front(), '0);
    id = live_q.pop_front();
    src_valid[1] = 1'b1;
    src_id[1]    = id;
    repeat (10) begin
      @(negedge clk);
      check_bit("int_stall", src_stall[1], 1'b1);
      check_bit("pb_we", pb_we, 1'b0);
      @(posedge clk);
      #2;
    end
    pb_full = 1'b0;
    return_ray(1, id, '0);
    drain_results();
  endtask

  task automatic recycle_ray_id;
    ray_id_t id;
    ray_id_t back;
    int      waited;
    repeat (free_q.size()) issue_ray(id, waited);
    prg_valid = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_bit("prg_stall", prg_stall, 1'b1);
      check_bit("raystore_we", raystore_we, 1'b0);
      @(posedge clk);
      #2;
    end
    prg_valid = 1'b0;
    back = live_q[100];
    live_q.delete(100);
    return_ray(3, back, '0);
    issue_ray(id, waited);
    check_ray_id("recycled ray id", id, back);
    drain_results();
  endtask

  initial begin
    rst_n        = 1'b0;
    prg_valid    = 1'b0;
    prg_pixel_id = '0;
    prg_origin   = '0;
    prg_dir      = '0;
    src_valid    = '0;
    for (int s = 0; s < 4; s++) src_id[s] = '0;
    pcalc_tri_id = '0;
    pb_full      = 1'b0;
    sint_stall   = 1'b0;
    rng          = 32'h7d0e;
    for (int i = 0; i < NUM_RAYS; i++) free_q.push_back(ray_id_t'(i));
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    issue_after_init();
    shade_returned_rays();
    round_robin_arbitration();
    hold_pixel_buffer();
    recycle_ray_id();
    $display("%0d errors counted", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ray_shader_top.sv */
`default_nettype none

module ray_shader_top (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  prg_valid,
  input  shader_pkg::pixel_id_t prg_pixel_id,
  input  shader_pkg::vec3_t     prg_origin,
  input  shader_pkg::vec3_t     prg_dir,
  output logic                  prg_stall,

  // result sources
  input  logic                  pcalc_valid,
  input  shader_pkg::ray_id_t   pcalc_ray_id,
  input  shader_pkg::tri_id_t   pcalc_tri_id,
  output logic                  pcalc_stall,
  input  logic                  int_valid,
  input  shader_pkg::ray_id_t   int_ray_id,
  output logic                  int_stall,
  input  logic                  sint_res_valid,
  input  shader_pkg::ray_id_t   sint_res_ray_id,
  output logic                  sint_res_stall,
  input  logic                  ss_valid,
  input  shader_pkg::ray_id_t   ss_ray_id,
  output logic                  ss_stall,

  output logic                  pb_we,
  output shader_pkg::pixel_id_t pb_pixel_id,
  output shader_pkg::color_t    pb_color,
  input  logic                  pb_full,

  output logic                  sint_valid,
  output shader_pkg::ray_id_t   sint_ray_id,
  output shader_pkg::vec3_t     sint_origin,
  output shader_pkg::vec3_t     sint_dir,
  input  logic                  sint_stall,

  output logic                  raystore_we,
  output shader_pkg::ray_id_t   raystore_addr,
  output shader_pkg::vec3_t     raystore_origin,
  output shader_pkg::vec3_t     raystore_dir
);

  shade_req_if req_if ();

  // source 0 is pcalc, pcalc and int count as hits
  result_arbiter result_arbiter_inst (
    .clk,
    .rst_n,
    .valid  ({ss_valid, sint_res_valid, int_valid, pcalc_valid}),
    .ray_id ({ss_ray_id, sint_res_ray_id, int_ray_id, pcalc_ray_id}),
    .hit    (4'b0011),
    .tri_id ({{3{16'h0000}}, pcalc_tri_id}),
    .stall  ({ss_stall, sint_res_stall, int_stall, pcalc_stall}),
    .req    (req_if.arb)
  );

  simple_shader_unit simple_shader_unit_inst (
    .clk,
    .rst_n,
    .prg_to_shader_valid    (prg_valid),
    .prg_to_shader_pixel_id (prg_pixel_id),
    .prg_to_shader_origin   (prg_origin),
    .prg_to_shader_dir      (prg_dir),
    .prg_to_shader_stall    (prg_stall),
    .req                    (req_if.core),
    .shader_to_sint_valid   (sint_valid),
    .shader_to_sint_ray_id  (sint_ray_id),
    .shader_to_sint_origin  (sint_origin),
    .shader_to_sint_dir     (sint_dir),
    .shader_to_sint_stall   (sint_stall),
    .raystore_we,
    .raystore_addr,
    .raystore_origin,
    .raystore_dir,
    .pb_we,
    .pb_full,
    .pb_pixel_id,
    .pb_color
  );

endmodule

`default_nettype wire

/* rtl/simple_shader_unit.sv */
`default_nettype none

module simple_shader_unit (
  input  logic                  clk,
  input  logic                  rst_n,

  // primary rays in
  input  logic                  prg_to_shader_valid,
  input  shader_pkg::pixel_id_t prg_to_shader_pixel_id,
  input  shader_pkg::vec3_t     prg_to_shader_origin,
  input  shader_pkg::vec3_t     prg_to_shader_dir,
  output logic                  prg_to_shader_stall,

  // arbitrated results
  shade_req_if.core             req,

  // rays to the scene intersector
  output logic                  shader_to_sint_valid,
  output shader_pkg::ray_id_t   shader_to_sint_ray_id,
  output shader_pkg::vec3_t     shader_to_sint_origin,
  output shader_pkg::vec3_t     shader_to_sint_dir,
  input  logic                  shader_to_sint_stall,

  output logic                  raystore_we,
  output shader_pkg::ray_id_t   raystore_addr,
  output shader_pkg::vec3_t     raystore_origin,
  output shader_pkg::vec3_t     raystore_dir,

  output logic                  pb_we,
  input  logic                  pb_full,
  output shader_pkg::pixel_id_t pb_pixel_id,
  output shader_pkg::color_t    pb_color
);
  import shader_pkg::*;

  ray_id_t   fl_head;
  logic      fl_empty;
  logic      fl_started;
  logic      in_init;
  logic      issue;
  logic      accept;
  logic      q_ready;
  pixel_id_t pix_mem [NUM_RAYS];
  pixel_id_t pix_rd;
  logic      acc_q;
  logic      hit_q;
  tri_id_t   tri_q;

  ray_id_free_list free_list_inst (
    .clk,
    .rst_n,
    .ret_valid (accept),
    .ret_id    (req.ray_id),
    .alloc     (issue),
    .head_id   (fl_head),
    .empty     (fl_empty)
  );

  // list only goes non-empty once the fill is done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fl_started <= 1'b0;
    end else begin
      fl_started <= fl_started | ~fl_empty;
    end
  end

  assign in_init = ~fl_started & fl_empty;

  // --------------------------------------------------
  // ray issue
  // --------------------------------------------------
  assign prg_to_shader_stall   = shader_to_sint_stall | fl_empty;
  assign shader_to_sint_valid  = prg_to_shader_valid & ~fl_empty;
  assign issue                 = prg_to_shader_valid & ~prg_to_shader_stall;

  assign shader_to_sint_ray_id = fl_head;
  assign shader_to_sint_origin = prg_to_shader_origin;
  assign shader_to_sint_dir    = prg_to_shader_dir;

  assign raystore_we     = issue;
  assign raystore_addr   = fl_head;
  assign raystore_origin = prg_to_shader_origin;
  assign raystore_dir    = prg_to_shader_dir;

  // --------------------------------------------------
  // pixel memory, written on issue, read on result
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (issue) begin
      pix_mem[fl_head] <= prg_to_shader_pixel_id;
    end
    pix_rd <= pix_mem[req.ray_id];
  end

  // --------------------------------------------------
  // result acceptance
  // --------------------------------------------------
  assign req.stall = req.valid & (in_init | ~q_ready);
  assign accept    = req.valid & ~req.stall;

  // hit info lines up with the memory read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= 1'b0;
    end else begin
      acc_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    hit_q <= req.hit;
    tri_q <= req.tri_id;
  end

  shade_queue shade_queue_inst (
    .clk,
    .rst_n,
    .in_valid    (acc_q),
    .in_pixel_id (pix_rd),
    .in_hit      (hit_q),
    .in_tri_id   (tri_q),
    .pb_full,
    .ready       (q_ready),
    .pb_we,
    .pb_pixel_id,
    .pb_color
  );

endmodule

`default_nettype wire

/* rtl/shade_queue.sv */
`default_nettype none

module shade_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  shader_pkg::pixel_id_t in_pixel_id,
  input  logic                  in_hit,
  input  shader_pkg::tri_id_t   in_tri_id,
  input  logic                  pb_full,
  output logic                  ready,
  output logic                  pb_we,
  output shader_pkg::pixel_id_t pb_pixel_id,
  output shader_pkg::color_t    pb_color
);
  import shader_pkg::*;

  pixel_id_t              pix_q [QUEUE_DEPTH];
  logic                   hit_q [QUEUE_DEPTH];
  tri_id_t                tri_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_PTR_W:0]   fifo_count;
  logic [QUEUE_PTR_W:0]   credit;
  logic                   fifo_we;
  logic                   fifo_re;
  logic                   fifo_empty;
  logic                   fifo_full;

  // --------------------------------------------------
  // credit covers the entry still in the read stage
  // --------------------------------------------------
  assign credit = fifo_count + in_valid;
  assign ready  = (credit < QUEUE_DEPTH);

  assign fifo_empty = (fifo_count == '0);
  assign fifo_full  = (fifo_count == QUEUE_DEPTH);
  assign fifo_we    = in_valid;
  assign fifo_re    = !fifo_empty && !pb_full;

  always_ff @(posedge clk) begin
    if (fifo_we) begin
      pix_q[wr_ptr] <= in_pixel_id;
      hit_q[wr_ptr] <= in_hit;
      tri_q[wr_ptr] <= in_tri_id;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (fifo_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count + fifo_we - fifo_re;
    end
  end

  // --------------------------------------------------
  // pixel buffer side
  // --------------------------------------------------
  function automatic color_t tri_color(input logic hit, input tri_id_t tri_id);
    if (!hit) begin
      return MISS_COLOR;
    end
    case (tri_id[1:0])
      2'd0:    return TRI0_COLOR;
      2'd1:    return TRI1_COLOR;
      2'd2:    return TRI2_COLOR;
      default: return TRI3_COLOR;
    endcase
  endfunction

  assign pb_we       = fifo_re;
  assign pb_pixel_id = pix_q[rd_ptr];
  assign pb_color    = tri_color(hit_q[rd_ptr], tri_q[rd_ptr]);

  // upstream credit check keeps this from happening
  no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) fifo_we |-> !fifo_full
  );

endmodule

`default_nettype wire

/* rtl/result_arbiter.sv */
`default_nettype none

module result_arbiter (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [shader_pkg::NUM_SRC-1:0]                valid,
  input  shader_pkg::ray_id_t [shader_pkg::NUM_SRC-1:0] ray_id,
  input  logic [shader_pkg::NUM_SRC-1:0]                hit,
  input  shader_pkg::tri_id_t [shader_pkg::NUM_SRC-1:0] tri_id,
  output logic [shader_pkg::NUM_SRC-1:0]                stall,
  shade_req_if.arb                                      req
);
  import shader_pkg::*;

  logic [SRC_IDX_W-1:0] last;
  logic [SRC_IDX_W-1:0] sel;
  logic [SRC_IDX_W-1:0] idx;
  logic [NUM_SRC-1:0]   grant;

  // --------------------------------------------------
  // pick the first valid source after the last winner
  // --------------------------------------------------
  always_comb begin
    grant = '0;
    sel   = last;
    idx   = last;
    for (int k = 1; k <= NUM_SRC; k++) begin
      idx = SRC_IDX_W'((int'(last) + k) % NUM_SRC);
      if (valid[idx] && grant == '0) begin
        grant[idx] = 1'b1;
        sel        = idx;
      end
    end
  end

  assign req.valid  = |grant;
  assign req.ray_id = ray_id[sel];
  assign req.hit    = hit[sel];
  assign req.tri_id = tri_id[sel];

  // losers wait, winner follows the core
  assign stall = ~grant | {NUM_SRC{req.stall}};

  // pointer only moves on a real transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last <= SRC_IDX_W'(NUM_SRC - 1);
    end else if (req.valid && !req.stall) begin
      last <= sel;
    end
  end

  grant_onehot_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
      $onehot0(grant) && ((grant & ~valid) == '0)
  );

endmodule

`default_nettype wire

/* rtl/ray_id_free_list.sv */
`default_nettype none

module ray_id_free_list (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ret_valid,
  input  shader_pkg::ray_id_t ret_id,
  input  logic               alloc,
  output shader_pkg::ray_id_t head_id,
  output logic               empty
);
  import shader_pkg::*;

  ray_id_t                 mem [NUM_RAYS];
  ray_id_t                 head;
  ray_id_t                 tail;
  logic [RAY_ID_W:0]       count;
  ray_id_t                 init_cnt;
  free_state_t             state;
  logic                    wr_en;
  ray_id_t                 wr_data;
  logic                    full;

  // --------------------------------------------------
  // fill after reset, then recycled ids
  // --------------------------------------------------
  assign wr_en   = (state == INIT) | ret_valid;
  assign wr_data = (state == INIT) ? init_cnt : ret_id;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[tail] <= wr_data;
    end
  end

  // head visible in the same cycle
  assign head_id = mem[head];
  assign empty   = (state == INIT) || (count == '0);
  assign full    = (count == NUM_RAYS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= INIT;
      init_cnt <= '0;
      head     <= '0;
      tail     <= '0;
      count    <= '0;
    end else if (state == INIT) begin
      init_cnt <= init_cnt + 1'b1;
      tail     <= tail + 1'b1;
      count    <= count + 1'b1;
      if (init_cnt == ray_id_t'(NUM_RAYS - 1)) begin
        state <= RUN;
      end
    end else begin
      if (ret_valid) begin
        tail <= tail + 1'b1;
      end
      if (alloc) begin
        head <= head + 1'b1;
      end
      count <= count + ret_valid - alloc;
    end
  end

  // issue side must look at empty first
  alloc_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) alloc |-> !empty
  );

  // only handed-out ids come back
  return_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) ret_valid |-> (state == RUN) && !full
  );

endmodule

`default_nettype wire

/* rtl/shade_req_if.sv */
`default_nettype none

// one arbitrated result heading into the shader core
interface shade_req_if;
  import shader_pkg::*;

  logic    valid;
  logic    stall;
  ray_id_t ray_id;
  logic    hit;
  tri_id_t tri_id;

  modport arb (
    output valid, ray_id, hit, tri_id,
    input  stall
  );

  modport core (
    input  valid, ray_id, hit, tri_id,
    output stall
  );

endinterface

`default_nettype wire

/* rtl/shader_pkg.sv */
`default_nettype none

package shader_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int NUM_RAYS    = 512;
  localparam int RAY_ID_W    = $clog2(NUM_RAYS);
  localparam int PIXEL_ID_W  = 19;
  localparam int TRI_ID_W    = 16;
  localparam int COORD_W     = 16;
  localparam int COLOR_W     = 24;

  // result sources: pcalc, int, sint, ss
  localparam int NUM_SRC     = 4;
  localparam int SRC_IDX_W   = $clog2(NUM_SRC);

  // shade queue
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [RAY_ID_W-1:0]   ray_id_t;
  typedef logic [PIXEL_ID_W-1:0] pixel_id_t;
  typedef logic [TRI_ID_W-1:0]   tri_id_t;

  // x in the top third, z in the bottom
  typedef logic [3*COORD_W-1:0]  vec3_t;

  // 8 bits each, red on top
  typedef logic [COLOR_W-1:0]    color_t;

  typedef enum logic {
    INIT,
    RUN
  } free_state_t;

  // --------------------------------------------------
  // colours
  // --------------------------------------------------
  localparam color_t MISS_COLOR = 24'h202040;
  localparam color_t TRI0_COLOR = 24'hff0000;
  localparam color_t TRI1_COLOR = 24'h00ff00;
  localparam color_t TRI2_COLOR = 24'h0000ff;
  localparam color_t TRI3_COLOR = 24'hffff00;

endpackage

`default_nettype wire
